/* source/spi_wb_settings.svh */
`ifndef SPI_WB_SETTINGS_SVH
`define SPI_WB_SETTINGS_SVH

// Word address carried in each SPI frame
`define SPI_WB_ADDR_W 20

// Wishbone data bus width
`define SPI_WB_DATA_W 32

// SCK edges per frame
// 20 address, 1 rnw, 3 dummy, 32 data
`define SPI_WB_FRAME_BITS 56

// Registers behind the bridge
`define SPI_WB_BANK_WORDS 64

`endif

/* source/spi_wb_pkg.sv */
`include "spi_wb_settings.svh"

package spi_wb_pkg;

    // Byte address, word address plus two zero bits
    typedef logic [`SPI_WB_ADDR_W+1:0] wb_adr_t;
    typedef logic [`SPI_WB_DATA_W-1:0] wb_dat_t;
    // One select bit per byte lane
    typedef logic [`SPI_WB_DATA_W/8-1:0] wb_sel_t;

    // Master to slave, 61 bits
    typedef struct packed {
        wb_adr_t adr;
        wb_dat_t dat;
        wb_sel_t sel;
        logic    we;
        logic    cyc;
        logic    stb;
    } wb_req_t;

    // Slave to master, 33 bits
    typedef struct packed {
        wb_dat_t dat;
        logic    ack;
    } wb_rsp_t;

    // Where the bit counter sits inside a frame
    typedef enum logic [1:0] {
        PH_ADDR,
        PH_DUMMY,
        PH_DATA,
        PH_DONE
    } frame_phase_e;

    // Encoding follows the rnw bit on the wire
    typedef enum logic {
        DIR_WRITE = 1'b0,
        DIR_READ  = 1'b1
    } spi_dir_e;

endpackage

/* source/spi_wb_bridge.sv */
`include "spi_wb_settings.svh"

module spi_wb_bridge (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,
    input  logic                spi_sck_i,
    input  logic                spi_mosi_i,
    input  logic                spi_cs_n_i,
    output logic                spi_miso_o,
    output spi_wb_pkg::wb_req_t bus_req_o,
    input  spi_wb_pkg::wb_rsp_t bus_rsp_i
);
    import spi_wb_pkg::*;

    // Counter values, each one is the index of the bit being sampled
    localparam logic [6:0] CNT_DUMMY0 = 7'(`SPI_WB_ADDR_W + 1);
    localparam logic [6:0] CNT_DIS_HI = 7'(`SPI_WB_ADDR_W + 2);
    localparam logic [6:0] CNT_DIS_LO = 7'(`SPI_WB_ADDR_W + 3);
    localparam logic [6:0] CNT_DATA   = 7'(`SPI_WB_FRAME_BITS - `SPI_WB_DATA_W);
    localparam logic [6:0] CNT_LAST   = 7'(`SPI_WB_FRAME_BITS - 1);
    localparam logic [6:0] CNT_END    = 7'(`SPI_WB_FRAME_BITS);

    logic [1:0]                sck_sync_q;
    logic [1:0]                cs_sync_q;
    logic [1:0]                mosi_sync_q;
    logic                      sck_prev_q;
    logic                      sck_rise;
    logic [6:0]                bit_cnt_q;
    frame_phase_e              phase;
    logic                      shift_en;
    wb_dat_t                   shift_q;
    logic [`SPI_WB_ADDR_W-1:0] addr_q;
    spi_dir_e                  dir_q;
    logic                      dis_hi_q;
    logic                      dis_lo_q;
    logic                      cyc_q;
    logic                      start_rd;
    logic                      start_wr;

    // Two flops per SPI pin into the bus clock domain
    // Chip select parks high so the bridge starts deselected
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            sck_sync_q  <= '0;
            cs_sync_q   <= '1;
            mosi_sync_q <= '0;
            sck_prev_q  <= 1'b0;
        end else begin
            sck_sync_q  <= {sck_sync_q[0], spi_sck_i};
            cs_sync_q   <= {cs_sync_q[0], spi_cs_n_i};
            mosi_sync_q <= {mosi_sync_q[0], spi_mosi_i};
            sck_prev_q  <= sck_sync_q[1];
        end
    end

    // Mode 0 rising edge, only counts while selected
    assign sck_rise = sck_sync_q[1] & ~sck_prev_q & ~cs_sync_q[1];

    // Bit counter, cleared whenever select is high
    // Stops at the frame length
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            bit_cnt_q <= '0;
        end else if (cs_sync_q[1]) begin
            bit_cnt_q <= '0;
        end else if (sck_rise && phase != PH_DONE) begin
            bit_cnt_q <= bit_cnt_q + 7'd1;
        end
    end

    always_comb begin
        if (bit_cnt_q < CNT_DUMMY0) begin
            phase = PH_ADDR;
        end else if (bit_cnt_q < CNT_DATA) begin
            phase = PH_DUMMY;
        end else if (bit_cnt_q < CNT_END) begin
            phase = PH_DATA;
        end else begin
            phase = PH_DONE;
        end
    end

    // Shifter holds still over the dummy bits
    // That keeps the read word parked with its MSB on MISO
    assign shift_en = sck_rise && (phase == PH_ADDR || phase == PH_DATA);

    // Read goes out as soon as rnw is known, write after the last data bit
    assign start_rd = sck_rise && bit_cnt_q == CNT_DUMMY0
                      && spi_dir_e'(shift_q[0]) == DIR_READ;
    assign start_wr = sck_rise && bit_cnt_q == CNT_LAST && dir_q == DIR_WRITE;

    // Address, direction and lane disables
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            addr_q   <= '0;
            dir_q    <= DIR_WRITE;
            dis_hi_q <= 1'b0;
            dis_lo_q <= 1'b0;
        end else if (sck_rise) begin
            // rnw in bit 0, address just above it
            if (bit_cnt_q == CNT_DUMMY0) begin
                addr_q <= shift_q[`SPI_WB_ADDR_W:1];
                dir_q  <= spi_dir_e'(shift_q[0]);
            end
            // Dummy bits straight off the synced MOSI
            if (bit_cnt_q == CNT_DIS_HI) begin
                dis_hi_q <= mosi_sync_q[1];
            end
            if (bit_cnt_q == CNT_DIS_LO) begin
                dis_lo_q <= mosi_sync_q[1];
            end
        end
    end

    // Cycle held until the slave acks
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            cyc_q <= 1'b0;
        end else if (cyc_q && bus_rsp_i.ack) begin
            cyc_q <= 1'b0;
        end else if (start_rd || start_wr) begin
            cyc_q <= 1'b1;
        end
    end

    // One shifter for address in, data in and read data out
    // Read data load wins over a shift in the same cycle
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            shift_q <= '0;
        end else if (cyc_q && bus_rsp_i.ack && dir_q == DIR_READ) begin
            shift_q <= bus_rsp_i.dat;
        end else if (shift_en) begin
            shift_q <= {shift_q[`SPI_WB_DATA_W-2:0], mosi_sync_q[1]};
        end
    end

    assign spi_miso_o = shift_q[`SPI_WB_DATA_W-1];

    always_comb begin
        bus_req_o.adr = {addr_q, 2'b00};
        bus_req_o.dat = shift_q;
        // Each disable bit masks a half-word
        bus_req_o.sel = {{2{~dis_hi_q}}, {2{~dis_lo_q}}};
        bus_req_o.we  = (dir_q == DIR_WRITE);
        bus_req_o.cyc = cyc_q;
        bus_req_o.stb = cyc_q;
    end

endmodule

/* source/wb_reg_bank.sv */
`include "spi_wb_settings.svh"

module wb_reg_bank (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,
    input  spi_wb_pkg::wb_req_t bus_req_i,
    output spi_wb_pkg::wb_rsp_t bus_rsp_o
);
    import spi_wb_pkg::*;

    localparam int IDX_W = $clog2(`SPI_WB_BANK_WORDS);
    localparam int LANES = `SPI_WB_DATA_W / 8;

    wb_dat_t                   regs_q [`SPI_WB_BANK_WORDS];
    logic [`SPI_WB_ADDR_W-1:0] word_adr;
    logic [IDX_W-1:0]          idx;
    logic                      in_range;
    logic                      req_new;
    logic                      ack_q;
    wb_dat_t                   rdat_q;

    // Drop the byte offset
    assign word_adr = bus_req_i.adr[`SPI_WB_ADDR_W+1:2];
    assign idx      = word_adr[IDX_W-1:0];
    // Out of range words still get an ack
    assign in_range = (word_adr < `SPI_WB_ADDR_W'(`SPI_WB_BANK_WORDS));

    // Strobe not yet answered
    assign req_new = bus_req_i.cyc && bus_req_i.stb && !ack_q;

    // Byte lane writes
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `SPI_WB_BANK_WORDS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (req_new && bus_req_i.we && in_range) begin
            for (int b = 0; b < LANES; b++) begin
                if (bus_req_i.sel[b]) begin
                    regs_q[idx][8*b +: 8] <= bus_req_i.dat[8*b +: 8];
                end
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge wb_clk_i) begin
        if (req_new) begin
            rdat_q <= in_range ? regs_q[idx] : '0;
        end
    end

    // Single cycle ack, one clock after stb
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new;
        end
    end

    always_comb begin
        bus_rsp_o.dat = rdat_q;
        bus_rsp_o.ack = ack_q;
    end

endmodule

/* source/spi_wb_top.sv */
module spi_wb_top (
    input  logic wb_clk_i,
    input  logic rst_n_i,
    input  logic spi_sck_i,
    input  logic spi_mosi_i,
    input  logic spi_cs_n_i,
    output logic spi_miso_o
);
    import spi_wb_pkg::*;

    // Bridge to bank
    wb_req_t bus_req;
    // Bank back to bridge
    wb_rsp_t bus_rsp;

    spi_wb_bridge i_spi_wb_bridge (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .spi_sck_i  (spi_sck_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_miso_o (spi_miso_o),
        .bus_req_o  (bus_req),
        .bus_rsp_i  (bus_rsp)
    );

    // Register file as the only slave
    wb_reg_bank i_wb_reg_bank (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp)
    );

endmodule

/* testbench/spi_wb_asserts.sv */
module spi_wb_asserts (
    input logic                wb_clk_i,
    input logic                rst_n_i,
    input spi_wb_pkg::wb_req_t bus_req_i,
    input spi_wb_pkg::wb_rsp_t bus_rsp_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import spi_wb_pkg::*;

    // Strobe only inside a cycle
    a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        bus_req_i.stb |-> bus_req_i.cyc)
        else $error("stb high while cyc is low");

    // Master holds address and lanes until the slave answers
    a_req_stable: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (bus_req_i.cyc && !bus_rsp_i.ack)
        |=> ($stable(bus_req_i.adr) && $stable(bus_req_i.sel)))
        else $error("adr or sel changed before ack");

    // No answer without a request
    a_ack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        bus_rsp_i.ack |-> bus_req_i.stb)
        else $error("ack seen while stb is low");

    // Word aligned byte address
    a_adr_aligned: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        bus_req_i.adr[1:0] == 2'b00)
        else $error("low address bits are not zero");

endmodule

/* testbench/spi_wb_tb.sv */
`include "spi_wb_settings.svh"

module spi_wb_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import spi_wb_pkg::*;

    localparam int FRAME_BITS = `SPI_WB_FRAME_BITS;
    localparam int DATA_FIRST = `SPI_WB_FRAME_BITS - `SPI_WB_DATA_W;
    localparam int BANK_WORDS = `SPI_WB_BANK_WORDS;
    localparam int SCK_HALF   = 4;
    localparam int BIT_CYCLES = 2 * SCK_HALF;
    localparam logic [6:0] NO_ABORT = 7'(`SPI_WB_FRAME_BITS);
    // Dummy field is sent MSB first, bit 2 is ignored by the bridge
    localparam logic [2:0] DUMMY_NONE = 3'b000;
    localparam logic [2:0] DUMMY_SKIP = 3'b100;
    localparam logic [2:0] NO_HI      = 3'b010;
    localparam logic [2:0] NO_LO      = 3'b001;

    // One row of the stimulus table
    typedef struct packed {
        spi_dir_e                  dir;
        logic [`SPI_WB_ADDR_W-1:0] addr;
        logic [2:0]                dummy;
        wb_dat_t                   wdata;
        logic [6:0]                abort_at;
        wb_dat_t                   exp_rdata;
    } stim_t;

    logic    wb_clk = 1'b0;
    logic    rst_n = 1'b0;
    logic    spi_sck = 1'b0;
    logic    spi_mosi = 1'b0;
    logic    spi_cs_n = 1'b1;
    logic    spi_miso;
    stim_t   stim_q[$];
    wb_dat_t model[BANK_WORDS];
    int      cycle_cnt = 0;

    spi_wb_top i_spi_wb_top (
        .wb_clk_i   (wb_clk),
        .rst_n_i    (rst_n),
        .spi_sck_i  (spi_sck),
        .spi_mosi_i (spi_mosi),
        .spi_cs_n_i (spi_cs_n),
        .spi_miso_o (spi_miso)
    );

    // Bus protocol checks on the bridge side
    bind spi_wb_bridge spi_wb_asserts i_spi_wb_asserts (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .bus_req_i (bus_req_o),
        .bus_rsp_i (bus_rsp_i)
    );

    initial begin
        forever #4 wb_clk = ~wb_clk;
    end

    task automatic stop_on_error(input string why);
        $display("Test FAILED");
        $fatal(1, why);
    endtask

    // Every frame takes FRAME_BITS * BIT_CYCLES, plus slack for reset and gaps
    always @(posedge wb_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= stim_q.size() * FRAME_BITS * BIT_CYCLES + 200) begin
            stop_on_error("run exceeded its cycle limit, the DUT did not finish a frame");
        end
    end

    task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            stop_on_error("data mismatch");
        end
    endtask

    task automatic check_phase(input frame_phase_e exp);
        frame_phase_e act;
        act = i_spi_wb_top.i_spi_wb_bridge.phase;
        if (act !== exp) begin
            $display("[FAIL] phase expected %h actual %h", exp, act);
            stop_on_error("phase mismatch");
        end
    endtask

    // Second dummy bit masks the upper half, third the lower half
    function automatic wb_sel_t lanes_from_dummy(input logic [2:0] dummy);
        return {{2{~dummy[1]}}, {2{~dummy[0]}}};
    endfunction

    function automatic logic [`SPI_WB_ADDR_W-1:0] pick_addr();
        return `SPI_WB_ADDR_W'($urandom_range(BANK_WORDS - 1, 0));
    endfunction

    task automatic add_write(input logic [`SPI_WB_ADDR_W-1:0] addr, input logic [2:0] dummy,
                             input wb_dat_t data, input logic [6:0] abort_at);
        stim_t   e;
        wb_sel_t sel;
        e = '{DIR_WRITE, addr, dummy, data, abort_at, '0};
        sel = lanes_from_dummy(dummy);
        // Model only moves for complete, in-range frames
        if (abort_at == NO_ABORT && addr < BANK_WORDS) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    model[int'(addr)][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        stim_q.push_back(e);
    endtask

    task automatic add_read(input logic [`SPI_WB_ADDR_W-1:0] addr);
        stim_t e;
        e = '{DIR_READ, addr, DUMMY_NONE, '0, NO_ABORT, '0};
        if (addr < BANK_WORDS) begin
            e.exp_rdata = model[int'(addr)];
        end
        stim_q.push_back(e);
    endtask

    // Mode 0 master, MSB first, MISO taken on each falling SCK edge
    task automatic send_frame(input stim_t e, output wb_dat_t rdata);
        logic [FRAME_BITS-1:0] bits;
        bits = {e.addr, e.dir, e.dummy, e.wdata};
        rdata = '0;
        spi_cs_n = 1'b0;
        for (int i = 0; i < FRAME_BITS; i++) begin
            if (i == int'(e.abort_at)) break;
            spi_mosi = bits[FRAME_BITS-1-i];
            repeat (SCK_HALF) @(negedge wb_clk);
            spi_sck = 1'b1;
            repeat (SCK_HALF) @(negedge wb_clk);
            spi_sck = 1'b0;
            // Fall before rising edge i+1
            if (i + 1 >= DATA_FIRST && i + 1 < FRAME_BITS) begin
                rdata[FRAME_BITS-2-i] = spi_miso;
            end
        end
        spi_cs_n = 1'b1;
    endtask

    task automatic build_table();
        logic [`SPI_WB_ADDR_W-1:0] rnd_adr[4];
        // Empty bank after reset
        add_read(20'd0);
        add_read(20'd5);
        add_read(20'd17);
        add_read(20'd63);
        // Full words, one carrying the ignored dummy bit
        foreach (rnd_adr[k]) begin
            rnd_adr[k] = pick_addr();
            add_write(rnd_adr[k], (k == 2) ? DUMMY_SKIP : DUMMY_NONE, $urandom, NO_ABORT);
        end
        foreach (rnd_adr[k]) begin
            add_read(rnd_adr[k]);
        end
        // Half-word lane masks
        add_write(20'd42, DUMMY_NONE, $urandom, NO_ABORT);
        add_write(20'd42, NO_HI, $urandom, NO_ABORT);
        add_read(20'd42);
        add_write(20'd42, NO_LO, $urandom, NO_ABORT);
        add_read(20'd42);
        add_write(20'd42, NO_HI | NO_LO, $urandom, NO_ABORT);
        add_read(20'd42);
        // Past the end, with the low aliases watched
        add_write(20'd64, DUMMY_NONE, $urandom, NO_ABORT);
        add_write(20'hfffff, DUMMY_NONE, $urandom, NO_ABORT);
        add_read(20'd64);
        add_read(20'hfffff);
        add_read(20'd0);
        add_read(20'd63);
        // Chip select pulled early
        add_write(20'd7, DUMMY_NONE, $urandom, NO_ABORT);
        add_write(20'd7, DUMMY_NONE, $urandom, 7'd40);
        add_write(20'd7, DUMMY_NONE, $urandom, 7'd55);
        add_read(20'd7);
        add_write(20'd7, DUMMY_NONE, $urandom, NO_ABORT);
        add_read(20'd7);
        // Alternating traffic on one register
        add_read(20'd33);
        add_write(20'd33, DUMMY_NONE, $urandom, NO_ABORT);
        add_read(20'd33);
        add_write(20'd33, NO_LO, $urandom, NO_ABORT);
        add_read(20'd33);
    endtask

    initial begin
        wb_dat_t rdata;
        void'($urandom(32'hf2d1));
        foreach (model[k]) begin
            model[k] = '0;
        end
        build_table();
        repeat (4) @(posedge wb_clk);
        @(negedge wb_clk);
        rst_n = 1'b1;
        repeat (2) @(negedge wb_clk);
        check_phase(PH_ADDR);
        foreach (stim_q[n]) begin
            send_frame(stim_q[n], rdata);
            // Bus cycle has to close before the next frame
            while (i_spi_wb_top.bus_req.cyc) begin
                @(negedge wb_clk);
            end
            // Select high has to pass the synchronizer
            repeat (4) @(negedge wb_clk);
            if (stim_q[n].dir == DIR_READ) begin
                check_dat("rdata", stim_q[n].exp_rdata, rdata);
            end
            check_phase(PH_ADDR);
        end
        $display("Test OK");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+source
source/spi_wb_pkg.sv
source/spi_wb_bridge.sv
source/wb_reg_bank.sv
source/spi_wb_top.sv
testbench/spi_wb_asserts.sv
testbench/spi_wb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SPI to Wishbone bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f vlog.f \
    --top-module spi_wb_tb \
    -o spi_wb_sim

# Exit status of the simulation decides pass or fail
./obj_dir/spi_wb_sim
